// File: rtl/core_pkg.sv
package core_pkg;

  // Datapath and instruction widths
  localparam int DATA_W     = 32;
  localparam int INST_W     = 16;
  localparam int REG_ADDR_W = 4;
  localparam int NUM_REGS   = 16;
  localparam int LIT_W      = 8;

  // Issue queue sizing, credit counter must hold QUEUE_DEPTH
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W    = 3;

  // ALU operation codes
  localparam logic [2:0] OP_ADD = 3'd0;
  localparam logic [2:0] OP_SUB = 3'd1;
  localparam logic [2:0] OP_AND = 3'd2;
  localparam logic [2:0] OP_OR  = 3'd3;
  localparam logic [2:0] OP_XOR = 3'd4;
  localparam logic [2:0] OP_MOV = 3'd5;
  localparam logic [2:0] OP_SHL = 3'd6;
  localparam logic [2:0] OP_SHR = 3'd7;

  // Register form, form bit clear
  typedef struct packed {
    logic                                  form;
    logic [2:0]                            op;
    logic [REG_ADDR_W-1:0]                 rd;
    logic [REG_ADDR_W-1:0]                 rn;
    logic [INST_W-2*REG_ADDR_W-4-1:0]      unused;
  } inst_reg_t;

  // Literal form, form bit set
  typedef struct packed {
    logic                  form;
    logic [2:0]            op;
    logic [REG_ADDR_W-1:0] rd;
    logic [LIT_W-1:0]      lit;
  } inst_lit_t;

  // Both views share bit 15 as the form bit
  typedef union packed {
    inst_reg_t reg_form;
    inst_lit_t lit_form;
  } inst_u;

  typedef struct packed {
    logic [2:0]            op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rn;
    logic                  lit_sel;
    logic [DATA_W-1:0]     lit;
  } issue_t;

  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     value;
    flags_t                flags;
  } retire_t;

endpackage

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu import core_pkg::*; (
  input  logic [2:0]        op_i,
  input  logic [DATA_W-1:0] a_i,
  input  logic [DATA_W-1:0] b_i,
  output logic [DATA_W-1:0] result_o,
  output flags_t            flags_o
);

  logic [DATA_W:0] sum;
  logic [DATA_W:0] diff;

  // Subtract as a + ~b + 1 so the carry out means no borrow
  assign sum  = {1'b0, a_i} + {1'b0, b_i};
  assign diff = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;

  always_comb
  begin
    flags_o.c = 1'b0;
    flags_o.v = 1'b0;
    case (op_i)
      OP_ADD:
      begin
        result_o  = sum[DATA_W-1:0];
        flags_o.c = sum[DATA_W];
        flags_o.v = (a_i[DATA_W-1] == b_i[DATA_W-1]) &&
                    (sum[DATA_W-1] != a_i[DATA_W-1]);
      end
      OP_SUB:
      begin
        result_o  = diff[DATA_W-1:0];
        flags_o.c = diff[DATA_W];
        flags_o.v = (a_i[DATA_W-1] != b_i[DATA_W-1]) &&
                    (diff[DATA_W-1] != a_i[DATA_W-1]);
      end
      OP_AND:  result_o = a_i & b_i;
      OP_OR:   result_o = a_i | b_i;
      OP_XOR:  result_o = a_i ^ b_i;
      OP_MOV:  result_o = b_i;
      // Logical shifts by the low five bits only
      OP_SHL:  result_o = a_i << b_i[4:0];
      OP_SHR:  result_o = a_i >> b_i[4:0];
      default: result_o = '0;
    endcase
    flags_o.z = (result_o == '0);
    flags_o.n = result_o[DATA_W-1];
  end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder import core_pkg::*; (
  input  logic   core_clk,
  input  logic   rst_n_i,
  input  logic   inst_valid_i,
  input  inst_u  inst_i,
  output logic   inst_ready_o,
  input  logic   credit_i,
  output logic   push_o,
  output issue_t issue_o
);

  logic [CREDIT_W-1:0] credit_cnt;
  logic                accept;
  issue_t              issue_d;

  // One credit per free queue slot, decode register included
  assign inst_ready_o = (credit_cnt != '0);
  assign accept       = inst_valid_i & inst_ready_o;

  always_comb
  begin
    issue_d = '0;
    if (inst_i.lit_form.form)
    begin
      issue_d.op      = inst_i.lit_form.op;
      issue_d.rd      = inst_i.lit_form.rd;
      issue_d.lit_sel = 1'b1;
      issue_d.lit     = {{(DATA_W-LIT_W){1'b0}}, inst_i.lit_form.lit};
    end
    else
    begin
      issue_d.op      = inst_i.reg_form.op;
      issue_d.rd      = inst_i.reg_form.rd;
      issue_d.rn      = inst_i.reg_form.rn;
      issue_d.lit_sel = 1'b0;
    end
  end

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_cnt <= CREDIT_W'(QUEUE_DEPTH);
      push_o     <= 1'b0;
    end
    else
    begin
      push_o <= accept;
      // Spend on accept, refill on credit, both may land together
      case ({accept, credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (accept)
    begin
      issue_o <= issue_d;
    end
  end

endmodule

// File: rtl/issue_queue.sv
`timescale 1ns/10ps

module issue_queue import core_pkg::*; (
  input  logic   core_clk,
  input  logic   rst_n_i,
  input  logic   push_i,
  input  issue_t issue_i,
  output logic   head_valid_o,
  output issue_t head_o,
  input  logic   pop_i,
  output logic   credit_o
);

  issue_t                           mem [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [CREDIT_W-1:0]              count;
  logic                             do_pop;

  assign head_valid_o = (count != '0);
  assign head_o       = mem[rd_ptr];
  assign do_pop       = pop_i & head_valid_o;

  // Each released entry hands one credit back to the decoder
  assign credit_o = do_pop;

  // Storage, no overflow check since credits bound the pushes
  always_ff @(posedge core_clk)
  begin
    if (push_i)
    begin
      mem[wr_ptr] <= issue_i;
    end
  end

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/10ps

module exec_unit import core_pkg::*; (
  input  logic    core_clk,
  input  logic    rst_n_i,
  input  logic    head_valid_i,
  input  issue_t  head_i,
  output logic    pop_o,
  output logic    retire_valid_o,
  output retire_t retire_o,
  input  logic    retire_ready_i
);

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic              wb_valid;
  retire_t           wb;
  logic              retire_fire;
  logic              do_pop;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_result;
  flags_t            alu_flags;

  // Register read with bypass from the write-back stage
  function automatic logic [DATA_W-1:0] read_src(input logic [REG_ADDR_W-1:0] idx);
    logic [DATA_W-1:0] val;
    if (wb_valid && (wb.rd == idx))
    begin
      val = wb.value;
    end
    else
    begin
      val = regs[idx];
    end
    return val;
  endfunction

  assign retire_fire = wb_valid & retire_ready_i;

  // Take a new entry only if the write-back slot frees up this cycle
  assign pop_o  = head_valid_i & (~wb_valid | retire_ready_i);
  assign do_pop = pop_o;

  assign op_a = read_src(head_i.rd);
  assign op_b = head_i.lit_sel ? head_i.lit : read_src(head_i.rn);

  alu u_alu (
    .op_i     (head_i.op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wb_valid <= 1'b0;
    end
    else if (do_pop)
    begin
      wb_valid <= 1'b1;
    end
    else if (retire_fire)
    begin
      wb_valid <= 1'b0;
    end
  end

  // Write-back payload holds while the retire port stalls
  always_ff @(posedge core_clk)
  begin
    if (do_pop)
    begin
      wb.rd    <= head_i.rd;
      wb.value <= alu_result;
      wb.flags <= alu_flags;
    end
  end

  // Architectural state only changes on the retire handshake
  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (retire_fire)
    begin
      regs[wb.rd] <= wb.value;
    end
  end

  assign retire_valid_o = wb_valid;
  assign retire_o       = wb;

endmodule

// File: rtl/core_top.sv
`timescale 1ns/10ps

module core_top import core_pkg::*; (
  input  logic    core_clk,
  input  logic    rst_n_i,
  input  logic    inst_valid_i,
  input  inst_u   inst_i,
  output logic    inst_ready_o,
  output logic    retire_valid_o,
  output retire_t retire_o,
  input  logic    retire_ready_i
);

  logic   push;
  issue_t issue;
  logic   credit;
  logic   head_valid;
  issue_t head;
  logic   pop;

  // Producer, credit loop back from the queue
  inst_decoder u_decoder (
    .core_clk     (core_clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .inst_ready_o (inst_ready_o),
    .credit_i     (credit),
    .push_o       (push),
    .issue_o      (issue)
  );

  issue_queue u_queue (
    .core_clk     (core_clk),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .issue_i      (issue),
    .head_valid_o (head_valid),
    .head_o       (head),
    .pop_i        (pop),
    .credit_o     (credit)
  );

  exec_unit u_exec (
    .core_clk       (core_clk),
    .rst_n_i        (rst_n_i),
    .head_valid_i   (head_valid),
    .head_i         (head),
    .pop_o          (pop),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

endmodule

// File: tb/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction word, expected rd, expected value, expected flags {z, n, c, v}
// Each row reads rd as operand a and writes the result back to rd
localparam int NUM_ROWS = 32;

localparam logic [55:0] VECTORS [NUM_ROWS] = '{
  {16'h0120, 4'h1, 32'h0000_0000, 4'b1000},  // ADD r1,r2 on reset registers
  {16'hD105, 4'h1, 32'h0000_0005, 4'b0000},  // MOV r1,#05
  {16'h810A, 4'h1, 32'h0000_000F, 4'b0000},  // ADD r1,#0A
  {16'hD2FF, 4'h2, 32'h0000_00FF, 4'b0000},
  {16'hD300, 4'h3, 32'h0000_0000, 4'b1000},
  {16'h1310, 4'h3, 32'hFFFF_FFF1, 4'b0100},  // SUB r3,r1 with borrow
  {16'h0310, 4'h3, 32'h0000_0000, 4'b1010},  // Wrap to zero, carry out
  {16'hD401, 4'h4, 32'h0000_0001, 4'b0000},
  {16'hE41F, 4'h4, 32'h8000_0000, 4'b0100},  // SHL r4,#31
  {16'hD501, 4'h5, 32'h0000_0001, 4'b0000},
  {16'h1450, 4'h4, 32'h7FFF_FFFF, 4'b0011},  // Signed overflow on SUB
  {16'h0450, 4'h4, 32'h8000_0000, 4'b0101},  // Signed overflow on ADD
  {16'h2120, 4'h1, 32'h0000_000F, 4'b0000},
  {16'h3620, 4'h6, 32'h0000_00FF, 4'b0000},
  {16'h4610, 4'h6, 32'h0000_00F0, 4'b0000},
  {16'h6610, 4'h6, 32'h0078_0000, 4'b0000},  // SHL by r1 = 15
  {16'h7610, 4'h6, 32'h0000_00F0, 4'b0000},
  {16'hF602, 4'h6, 32'h0000_003C, 4'b0000},
  {16'hC4FF, 4'h4, 32'h8000_00FF, 4'b0100},
  {16'h1110, 4'h1, 32'h0000_0000, 4'b1010},
  {16'hD7AA, 4'h7, 32'h0000_00AA, 4'b0000},  // Chain through rn
  {16'h0870, 4'h8, 32'h0000_00AA, 4'b0000},
  {16'h0980, 4'h9, 32'h0000_00AA, 4'b0000},
  {16'h1980, 4'h9, 32'h0000_0000, 4'b1010},
  {16'h5A90, 4'hA, 32'h0000_0000, 4'b1000},
  {16'hAA33, 4'hA, 32'h0000_0000, 4'b1000},
  {16'hBB5C, 4'hB, 32'h0000_005C, 4'b0000},
  {16'h0BB0, 4'hB, 32'h0000_00B8, 4'b0000},
  {16'h0BB0, 4'hB, 32'h0000_0170, 4'b0000},
  {16'h9C80, 4'hC, 32'hFFFF_FF80, 4'b0100},
  {16'h8C80, 4'hC, 32'h0000_0000, 4'b1010},
  {16'h5DB0, 4'hD, 32'h0000_0170, 4'b0000}
};

`endif

// File: tb/tb_core_top.sv
`timescale 1ns/10ps

module tb_core_top import core_pkg::*; ();

  typedef struct packed {
    logic [INST_W-1:0]     word;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     value;
    flags_t                flags;
  } row_t;

  `include "tb_vectors.svh"

  // Retire port phases, counted in retired rows
  localparam int RANDOM_START   = 12;
  localparam int STALL_START    = 20;
  localparam int STALL_CYCLES   = 24;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (QUEUE_DEPTH + 8) + 16;
  localparam logic [31:0] LFSR_SEED = 32'h4b78;

  logic    core_clk;
  logic    rst_n;
  logic    inst_valid;
  inst_u   inst;
  logic    inst_ready;
  logic    retire_valid;
  retire_t retire;
  logic    retire_ready;

  int   errors = 0;
  int   retired = 0;
  logic saw_ready_low = 1'b0;

  core_top u_dut (
    .core_clk       (core_clk),
    .rst_n_i        (rst_n),
    .inst_valid_i   (inst_valid),
    .inst_i         (inst),
    .inst_ready_o   (inst_ready),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .retire_ready_i (retire_ready)
  );

  initial
  begin
    core_clk = 1'b0;
    forever #2 core_clk = ~core_clk;
  end

  task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  initial
  begin : stimulus
    row_t row;
    rst_n      <= 1'b0;
    inst_valid <= 1'b0;
    inst       <= '0;
    repeat (4) @(posedge core_clk);
    rst_n <= 1'b1;
    @(posedge core_clk);
    compare_value("retire_valid_o", DATA_W'(retire_valid), DATA_W'(0));
    compare_value("inst_ready_o", DATA_W'(inst_ready), DATA_W'(1));
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      row = row_t'(VECTORS[i]);
      inst_valid <= 1'b1;
      inst       <= row.word;
      // Hold the word until the decoder takes it
      @(posedge core_clk);
      while (!inst_ready)
        @(posedge core_clk);
    end
    inst_valid <= 1'b0;
    wait (retired == NUM_ROWS);
    repeat (QUEUE_DEPTH + 4) @(posedge core_clk);
    if (!saw_ready_low)
    begin
      $display("inst_ready_o never dropped while the retire port was stalled");
      errors++;
    end
    $display("Summary: %0d of %0d rows retired, %0d errors", retired, NUM_ROWS, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // Retire monitor and retire_ready driver
  initial
  begin : retire_side
    row_t        exp_row;
    retire_t     held;
    logic        was_stalled;
    logic [31:0] lfsr_state;
    int          stall_left;
    held         = '0;
    was_stalled  = 1'b0;
    lfsr_state   = LFSR_SEED;
    stall_left   = STALL_CYCLES;
    retire_ready <= 1'b1;
    forever
    begin
      @(posedge core_clk);
      if (rst_n)
      begin
        // Payload must hold through a stall
        if (was_stalled)
        begin
          compare_value("retire_valid_o", DATA_W'(retire_valid), DATA_W'(1));
          compare_value("retire_o.rd", DATA_W'(retire.rd), DATA_W'(held.rd));
          compare_value("retire_o.value", retire.value, held.value);
          compare_value("retire_o.flags", DATA_W'(retire.flags), DATA_W'(held.flags));
        end
        if (retire_valid && retire_ready)
        begin
          if (retired < NUM_ROWS)
          begin
            exp_row = row_t'(VECTORS[retired]);
            compare_value("retire_o.rd", DATA_W'(retire.rd), DATA_W'(exp_row.rd));
            compare_value("retire_o.value", retire.value, exp_row.value);
            compare_value("retire_o.flags", DATA_W'(retire.flags), DATA_W'(exp_row.flags));
          end
          else
          begin
            $display("Retire transfer seen after all %0d rows had retired", NUM_ROWS);
            errors++;
          end
          retired++;
        end
        was_stalled = retire_valid && !retire_ready;
        held        = retire;
        if (retired >= STALL_START && stall_left > 0)
        begin
          if (!inst_ready)
            saw_ready_low = 1'b1;
          stall_left--;
          retire_ready <= 1'b0;
        end
        else if (retired < RANDOM_START)
        begin
          retire_ready <= 1'b1;
        end
        else
        begin
          lfsr_state = next_lfsr(lfsr_state);
          retire_ready <= lfsr_state[0];
        end
      end
    end
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge core_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d rows retired",
             cycles, retired, NUM_ROWS);
    $display("Test failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+tb
rtl/core_pkg.sv
rtl/alu.sv
rtl/inst_decoder.sv
rtl/issue_queue.sv
rtl/exec_unit.sv
rtl/core_top.sv
tb/tb_core_top.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = tb_core_top
FILELIST   = project.f
BUILD_DIR  = obj_dir
PASS_MSG   = Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
